//--- all.f
rtl/memStagePkg.sv
rtl/memReqIf.sv
rtl/memRespIf.sv
rtl/storeAlign.sv
rtl/dataMemory.sv
rtl/timerBank.sv
rtl/memAccess.sv
rtl/loadExtend.sv
rtl/memSubsystem.sv
verification/memSubsystem_properties.sv
verification/memSubsystemTb.sv

//--- rtl/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
    input  wire logic        clk,
    input  wire logic [11:0] wordAddr,
    input  wire logic [3:0]  byteEn,
    input  wire logic [31:0] wdata,
    input  wire logic        readEn,
    output logic      [31:0] rdata
);

    logic [31:0] mem [memStagePkg::DM_WORDS];

    // Old contents are read when a write hits the same word
    always_ff @(posedge clk) begin
        if (readEn) begin
            rdata <= mem[wordAddr];
        end
    end

    ////////////////////
    // Byte lane writes
    ////////////////////
    always_ff @(posedge clk) begin
        if (byteEn[0]) begin
            mem[wordAddr][7:0] <= wdata[7:0];
        end
        if (byteEn[1]) begin
            mem[wordAddr][15:8] <= wdata[15:8];
        end
        if (byteEn[2]) begin
            mem[wordAddr][23:16] <= wdata[23:16];
        end
        if (byteEn[3]) begin
            mem[wordAddr][31:24] <= wdata[31:24];
        end
    end

endmodule

`default_nettype wire

//--- rtl/loadExtend.sv
`timescale 1ns/1ps
`default_nettype none

module loadExtend (
    input  wire logic  clk,
    input  wire logic  rstN,
    memRespIf.consumer resp,
    output logic       respValid,
    output logic [31:0] respRdata,
    output logic       excValid,
    output logic [4:0] excCode
);

    logic [15:0] halfSel;
    logic [7:0]  byteSel;
    logic [31:0] extended;

    assign halfSel = resp.lane[1] ? resp.rawData[31:16] : resp.rawData[15:0];
    assign byteSel = resp.rawData[resp.lane * 8 +: 8];

    // Sign or zero extension
    always_comb begin
        case (resp.size)
            memStagePkg::SIZE_HALF: extended = {{16{resp.isSigned && halfSel[15]}}, halfSel};
            memStagePkg::SIZE_BYTE: extended = {{24{resp.isSigned && byteSel[7]}}, byteSel};
            default:                extended = resp.rawData;
        endcase
    end

    ////////////////////
    // Result registers
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            respValid <= 1'b0;
            excValid <= 1'b0;
            excCode <= 5'd0;
        end else begin
            respValid <= resp.valid && resp.isLoad && !resp.exc;
            excValid <= resp.valid && resp.exc;
            excCode <= resp.excCode;
        end
    end

    always_ff @(posedge clk) begin
        respRdata <= extended;
    end

endmodule

`default_nettype wire

//--- rtl/memAccess.sv
`timescale 1ns/1ps
`default_nettype none

module memAccess (
    input  wire logic   clk,
    input  wire logic   rstN,
    memReqIf.consumer   req,
    memRespIf.producer  resp,
    output logic [1:0]  timerIrq
);

    logic        good;
    logic        isDm;
    logic [3:0]  ramByteEn;
    logic        ramRead;
    logic        periphSel;
    logic        periphWrite;
    logic [31:0] ramRdata;
    logic [31:0] periphRdata;
    logic        fromPeriph;

    ////////////////////
    // Region decode
    ////////////////////
    assign good = req.valid && !req.exc;
    assign isDm = req.addr <= memStagePkg::DM_LAST;

    assign ramByteEn = (good && isDm) ? req.byteEn : 4'b0000;
    assign ramRead = good && isDm && !req.write;

    assign periphSel = good && !isDm;
    // Peripherals take whole words only
    assign periphWrite = req.write && (&req.byteEn);

    dataMemory dataMemory_i (
        .clk      (clk),
        .wordAddr (req.addr[13:2]),
        .byteEn   (ramByteEn),
        .wdata    (req.wdata),
        .readEn   (ramRead),
        .rdata    (ramRdata)
    );

    timerBank timerBank_i (
        .clk      (clk),
        .rstN     (rstN),
        .sel      (periphSel),
        .write    (periphWrite),
        .regAddr  (req.addr[5:0]),
        .wdata    (req.wdata),
        .rdata    (periphRdata),
        .timerIrq (timerIrq)
    );

    ////////////////////
    // Side information delay
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resp.valid <= 1'b0;
            resp.isLoad <= 1'b0;
            resp.exc <= 1'b0;
        end else begin
            resp.valid <= req.valid;
            resp.isLoad <= req.valid && !req.write;
            resp.exc <= req.valid && req.exc;
        end
    end

    always_ff @(posedge clk) begin
        resp.size <= req.size;
        resp.isSigned <= req.isSigned;
        resp.lane <= req.lane;
        resp.excCode <= req.excCode;
        fromPeriph <= !isDm;
    end

    assign resp.rawData = fromPeriph ? periphRdata : ramRdata;

endmodule

`default_nettype wire

//--- rtl/memReqIf.sv
`timescale 1ns/1ps
`default_nettype none

// Aligned request from stage 1 to stage 2
interface memReqIf;
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [3:0]  byteEn;
    logic [31:0] wdata;
    logic [1:0]  size;
    logic        isSigned;
    logic [1:0]  lane;
    logic        exc;
    logic [4:0]  excCode;

    modport producer (
        output valid, write, addr, byteEn, wdata, size, isSigned, lane, exc, excCode
    );

    modport consumer (
        input valid, write, addr, byteEn, wdata, size, isSigned, lane, exc, excCode
    );
endinterface

`default_nettype wire

//--- rtl/memRespIf.sv
`timescale 1ns/1ps
`default_nettype none

// Raw read data and status from stage 2 to stage 3
interface memRespIf;
    logic        valid;
    logic        isLoad;
    logic [31:0] rawData;
    logic [1:0]  size;
    logic        isSigned;
    logic [1:0]  lane;
    logic        exc;
    logic [4:0]  excCode;

    modport producer (output valid, isLoad, rawData, size, isSigned, lane, exc, excCode);

    modport consumer (input valid, isLoad, rawData, size, isSigned, lane, exc, excCode);
endinterface

`default_nettype wire

//--- rtl/memStagePkg.sv
`default_nettype none

package memStagePkg;

    ////////////////////
    // Access sizes
    ////////////////////
    localparam logic [1:0] SIZE_WORD = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_BYTE = 2'd2;

    ////////////////////
    // Memory map
    ////////////////////
    localparam logic [31:0] DM_LAST = 32'h0000_2fff;
    localparam int unsigned DM_WORDS = 3072;

    localparam logic [31:0] TIMER0_BASE = 32'h0000_7f00;
    localparam logic [31:0] TIMER1_BASE = 32'h0000_7f10;
    localparam logic [31:0] TIMER_BYTES = 32'd12;

    localparam logic [31:0] SCRATCH_BASE = 32'h0000_7f20;
    localparam logic [31:0] SCRATCH_BYTES = 32'd4;

    // Register offsets inside one timer
    localparam logic [3:0] CTRL_OFS = 4'h0;
    localparam logic [3:0] PRESET_OFS = 4'h4;
    localparam logic [3:0] COUNT_OFS = 4'h8;

    ////////////////////
    // Exceptions and pipeline
    ////////////////////
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;

    localparam int unsigned PIPE_DEPTH = 3;

endpackage

`default_nettype wire

//--- rtl/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        reqValid,
    input  wire logic        reqWrite,
    input  wire logic [1:0]  reqSize,
    input  wire logic        reqSigned,
    input  wire logic [31:0] reqAddr,
    input  wire logic [31:0] reqWdata,
    input  wire logic        addrOverflow,
    output logic             respValid,
    output logic      [31:0] respRdata,
    output logic             excValid,
    output logic      [4:0]  excCode,
    output logic      [1:0]  timerIrq
);

    memReqIf reqBus ();
    memRespIf respBus ();

    // Stage 1
    storeAlign storeAlign_i (
        .clk          (clk),
        .rstN         (rstN),
        .reqValid     (reqValid),
        .reqWrite     (reqWrite),
        .reqSize      (reqSize),
        .reqSigned    (reqSigned),
        .reqAddr      (reqAddr),
        .reqWdata     (reqWdata),
        .addrOverflow (addrOverflow),
        .req          (reqBus)
    );

    // Stage 2
    memAccess memAccess_i (
        .clk      (clk),
        .rstN     (rstN),
        .req      (reqBus),
        .resp     (respBus),
        .timerIrq (timerIrq)
    );

    // Stage 3
    loadExtend loadExtend_i (
        .clk       (clk),
        .rstN      (rstN),
        .resp      (respBus),
        .respValid (respValid),
        .respRdata (respRdata),
        .excValid  (excValid),
        .excCode   (excCode)
    );

endmodule

`default_nettype wire

//--- rtl/storeAlign.sv
`timescale 1ns/1ps
`default_nettype none

module storeAlign (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        reqValid,
    input  wire logic        reqWrite,
    input  wire logic [1:0]  reqSize,
    input  wire logic        reqSigned,
    input  wire logic [31:0] reqAddr,
    input  wire logic [31:0] reqWdata,
    input  wire logic        addrOverflow,
    memReqIf.producer        req
);

    logic [1:0]  lane;
    logic [3:0]  laneEn;
    logic [31:0] laneData;
    logic        inDm;
    logic        inTimer0;
    logic        inTimer1;
    logic        inTimer;
    logic        inScratch;
    logic        isCount;
    logic        misalign;
    logic        badPeriphSize;
    logic        outOfRange;
    logic        fault;

    assign lane = reqAddr[1:0];

    ////////////////////
    // Lane table
    ////////////////////
    always_comb begin
        laneEn = 4'b0000;
        laneData = reqWdata;
        case (reqSize)
            memStagePkg::SIZE_WORD: begin
                laneEn = (lane == 2'b00) ? 4'b1111 : 4'b0000;
            end
            memStagePkg::SIZE_HALF: begin
                laneEn = lane[1] ? 4'b1100 : 4'b0011;
                laneData = {2{reqWdata[15:0]}};
            end
            memStagePkg::SIZE_BYTE: begin
                laneEn = 4'b0001 << lane;
                laneData = {4{reqWdata[7:0]}};
            end
            default: begin
                laneEn = 4'b0000;
            end
        endcase
    end

    ////////////////////
    // Address checks
    ////////////////////
    assign inDm = reqAddr <= memStagePkg::DM_LAST;
    assign inTimer0 = (reqAddr >= memStagePkg::TIMER0_BASE) &&
        (reqAddr <= memStagePkg::TIMER0_BASE + memStagePkg::TIMER_BYTES - 32'd1);
    assign inTimer1 = (reqAddr >= memStagePkg::TIMER1_BASE) &&
        (reqAddr <= memStagePkg::TIMER1_BASE + memStagePkg::TIMER_BYTES - 32'd1);
    assign inTimer = inTimer0 || inTimer1;
    assign inScratch = (reqAddr >= memStagePkg::SCRATCH_BASE) &&
        (reqAddr <= memStagePkg::SCRATCH_BASE + memStagePkg::SCRATCH_BYTES - 32'd1);

    // Timer bases sit on 16-byte boundaries, so the low nibble is the offset
    assign isCount = inTimer && (reqAddr[3:2] == memStagePkg::COUNT_OFS[3:2]);

    assign misalign = ((reqSize == memStagePkg::SIZE_WORD) && (lane != 2'b00)) ||
                      ((reqSize == memStagePkg::SIZE_HALF) && lane[0]);
    assign badPeriphSize = inTimer &&
        ((reqSize == memStagePkg::SIZE_HALF) || (reqSize == memStagePkg::SIZE_BYTE));
    assign outOfRange = !(inDm || inTimer || inScratch);

    assign fault = misalign || badPeriphSize || addrOverflow || outOfRange ||
                   (reqWrite && isCount);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            req.valid <= 1'b0;
            req.write <= 1'b0;
            req.exc <= 1'b0;
            req.byteEn <= 4'b0000;
        end else begin
            req.valid <= reqValid;
            req.write <= reqWrite;
            req.exc <= reqValid && fault;
            // Only a clean store may touch any lane
            req.byteEn <= (reqValid && reqWrite && !fault) ? laneEn : 4'b0000;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        req.addr <= {reqAddr[31:2], 2'b00};
        req.wdata <= laneData;
        req.size <= reqSize;
        req.isSigned <= reqSigned;
        req.lane <= lane;
        req.excCode <= reqWrite ? memStagePkg::EXC_ADES : memStagePkg::EXC_ADEL;
    end

endmodule

`default_nettype wire

//--- rtl/timerBank.sv
`timescale 1ns/1ps
`default_nettype none

module timerBank (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        sel,
    input  wire logic        write,
    input  wire logic [5:0]  regAddr,
    input  wire logic [31:0] wdata,
    output logic      [31:0] rdata,
    output logic      [1:0]  timerIrq
);

    logic [31:0] ctrl [2];
    logic [31:0] preset [2];
    logic [31:0] count [2];
    logic [31:0] scratch;
    logic        isScratch;
    logic        timerIdx;
    logic [3:0]  offset;
    logic [31:0] readMux;

    // Bit 5 picks the scratch word, bit 4 the timer
    assign isScratch = regAddr[5];
    assign timerIdx = regAddr[4];
    assign offset = regAddr[3:0];

    ////////////////////
    // Registers and countdown
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < 2; k++) begin
                ctrl[k] <= '0;
                preset[k] <= '0;
                count[k] <= '0;
            end
            scratch <= '0;
        end else begin
            for (int k = 0; k < 2; k++) begin
                if (sel && write && !isScratch && (timerIdx == k[0]) &&
                        (offset == memStagePkg::PRESET_OFS)) begin
                    preset[k] <= wdata;
                    count[k] <= wdata;
                end else if (ctrl[k][0] && (count[k] != '0)) begin
                    count[k] <= count[k] - 32'd1;
                end
                if (sel && write && !isScratch && (timerIdx == k[0]) &&
                        (offset == memStagePkg::CTRL_OFS)) begin
                    ctrl[k] <= wdata;
                end
            end
            if (sel && write && isScratch) begin
                scratch <= wdata;
            end
        end
    end

    always_comb begin
        if (isScratch) begin
            readMux = scratch;
        end else begin
            case (offset)
                memStagePkg::CTRL_OFS:   readMux = ctrl[timerIdx];
                memStagePkg::PRESET_OFS: readMux = preset[timerIdx];
                memStagePkg::COUNT_OFS:  readMux = count[timerIdx];
                default:                 readMux = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            rdata <= readMux;
        end
    end

    // Interrupt while enabled and expired
    assign timerIrq[0] = ctrl[0][0] && (count[0] == '0);
    assign timerIrq[1] = ctrl[1][0] && (count[1] == '0);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the memSubsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module memSubsystemTb \
    -f all.f -Mdir obj_dir -o memSubsystemSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memSubsystemSim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
else
    exit 1
fi

//--- verification/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

    localparam int WORD_PAIRS = 48;
    localparam int LANE_ROUNDS = 8;
    // Upper bound on the requests of all tests
    localparam int REQUEST_COUNT = 2 * WORD_PAIRS + 25 * LANE_ROUNDS + 40;

    localparam logic [31:0] CTRL0 = memStagePkg::TIMER0_BASE + 32'(memStagePkg::CTRL_OFS);
    localparam logic [31:0] PRESET0 = memStagePkg::TIMER0_BASE + 32'(memStagePkg::PRESET_OFS);
    localparam logic [31:0] COUNT0 = memStagePkg::TIMER0_BASE + 32'(memStagePkg::COUNT_OFS);

    typedef struct {
        int          due;
        logic        isLoad;
        logic        isExc;
        logic [31:0] data;
        logic [4:0]  code;
    } resultEntry;

    logic        clk;
    logic        rstN;
    logic        reqValid;
    logic        reqWrite;
    logic [1:0]  reqSize;
    logic        reqSigned;
    logic [31:0] reqAddr;
    logic [31:0] reqWdata;
    logic        addrOverflow;
    logic        respValid;
    logic [31:0] respRdata;
    logic        excValid;
    logic [4:0]  excCode;
    logic [1:0]  timerIrq;

    // Byte-wide reference copy of the data RAM
    logic [7:0]  refMem [16384];
    resultEntry  pending [$];
    logic [31:0] lfsr;
    int          cycle;

    memSubsystem memSubsystem_i (
        .clk          (clk),
        .rstN         (rstN),
        .reqValid     (reqValid),
        .reqWrite     (reqWrite),
        .reqSize      (reqSize),
        .reqSigned    (reqSigned),
        .reqAddr      (reqAddr),
        .reqWdata     (reqWdata),
        .addrOverflow (addrOverflow),
        .respValid    (respValid),
        .respRdata    (respRdata),
        .excValid     (excValid),
        .excCode      (excCode),
        .timerIrq     (timerIrq)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////
    // Helpers
    ////////////////////
    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] nextRandom(input int bits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < bits; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic logic [31:0] randomWordAddr();
        return {18'd0, 12'(nextRandom(12) % memStagePkg::DM_WORDS), 2'b00};
    endfunction

    function automatic int sizeBytes(input logic [1:0] size);
        case (size)
            memStagePkg::SIZE_HALF: return 2;
            memStagePkg::SIZE_BYTE: return 1;
            default:                return 4;
        endcase
    endfunction

    // Little-endian bytes from the model with sign or zero extension
    function automatic logic [31:0] modelLoad(input logic [1:0] size, input logic sgn,
                                              input logic [31:0] addr);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < sizeBytes(size); i++) begin
            word[8 * i +: 8] = refMem[14'(addr + 32'(i))];
        end
        case (size)
            memStagePkg::SIZE_HALF: return {{16{sgn && word[15]}}, word[15:0]};
            memStagePkg::SIZE_BYTE: return {{24{sgn && word[7]}}, word[7:0]};
            default:                return word;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        assert (got === want) else begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Result due PIPE_DEPTH cycles after the DUT samples the request
    function automatic void expectResult(input logic isLoad, input logic isExc,
                                         input logic [31:0] data, input logic [4:0] code);
        resultEntry e;
        e.due = cycle + 1 + int'(memStagePkg::PIPE_DEPTH);
        e.isLoad = isLoad;
        e.isExc = isExc;
        e.data = data;
        e.code = code;
        pending.push_back(e);
    endfunction

    // One clock edge with the outputs compared against the queue
    task automatic tick();
        resultEntry e;
        @(posedge clk);
        cycle++;
        if (memSubsystem_i.memSubsystemProps_i.failCount != 0) begin
            $display("A bound property failed before %0t ns", $time);
            $display("TESTBENCH FAILED");
            $fatal(1, "Property failure");
        end
        e = '{cycle, 1'b0, 1'b0, 32'h0, 5'h0};
        if ((pending.size() > 0) && (pending[0].due == cycle)) begin
            e = pending.pop_front();
        end
        checkValue("respValid", 32'(respValid), 32'(e.isLoad));
        checkValue("excValid", 32'(excValid), 32'(e.isExc));
        if (e.isLoad) begin
            checkValue("respRdata", respRdata, e.data);
        end
        if (e.isExc) begin
            checkValue("excCode", 32'(excCode), 32'(e.code));
        end
    endtask

    task automatic drive(input logic write, input logic [1:0] size, input logic sgn,
                         input logic [31:0] addr, input logic [31:0] data, input logic ovf);
        tick();
        reqValid <= 1'b1;
        reqWrite <= write;
        reqSize <= size;
        reqSigned <= sgn;
        reqAddr <= addr;
        reqWdata <= data;
        addrOverflow <= ovf;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            tick();
            reqValid <= 1'b0;
            addrOverflow <= 1'b0;
        end
    endtask

    task automatic storeRam(input logic [1:0] size, input logic [31:0] addr,
                            input logic [31:0] data);
        drive(1'b1, size, 1'b0, addr, data, 1'b0);
        for (int i = 0; i < sizeBytes(size); i++) begin
            refMem[14'(addr + 32'(i))] = data[8 * i +: 8];
        end
    endtask

    task automatic loadRam(input logic [1:0] size, input logic sgn, input logic [31:0] addr);
        drive(1'b0, size, sgn, addr, 32'h0, 1'b0);
        expectResult(1'b1, 1'b0, modelLoad(size, sgn, addr), 5'd0);
    endtask

    task automatic faultAccess(input logic write, input logic [1:0] size,
                               input logic [31:0] addr, input logic ovf);
        drive(write, size, 1'b0, addr, nextRandom(32), ovf);
        expectResult(1'b0, 1'b1, 32'h0,
                     write ? memStagePkg::EXC_ADES : memStagePkg::EXC_ADEL);
    endtask

    task automatic storePeriph(input logic [31:0] addr, input logic [31:0] data);
        drive(1'b1, memStagePkg::SIZE_WORD, 1'b0, addr, data, 1'b0);
    endtask

    task automatic loadPeriph(input logic [31:0] addr, input logic [31:0] want);
        drive(1'b0, memStagePkg::SIZE_WORD, 1'b0, addr, 32'h0, 1'b0);
        expectResult(1'b1, 1'b0, want, 5'd0);
    endtask

    ////////////////////
    // Tests
    ////////////////////
    initial begin
        logic [31:0] addr;
        logic [31:0] value;
        lfsr = 32'h3db4;
        cycle = 0;
        rstN = 1'b0;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqSize = memStagePkg::SIZE_WORD;
        reqSigned = 1'b0;
        reqAddr = 32'h0;
        reqWdata = 32'h0;
        addrOverflow = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        // Quiet outputs before any request
        idle(12);
        checkValue("timerIrq", 32'(timerIrq), 32'h0);

        // Each word load right behind its store
        for (int i = 0; i < WORD_PAIRS; i++) begin
            addr = randomWordAddr();
            storeRam(memStagePkg::SIZE_WORD, addr, nextRandom(32));
            loadRam(memStagePkg::SIZE_WORD, 1'b0, addr);
        end

        // Byte and half lanes
        for (int r = 0; r < LANE_ROUNDS; r++) begin
            addr = randomWordAddr();
            storeRam(memStagePkg::SIZE_WORD, addr, nextRandom(32));
            for (int lane = 0; lane < 4; lane++) begin
                storeRam(memStagePkg::SIZE_BYTE, addr + lane, nextRandom(32));
                loadRam(memStagePkg::SIZE_BYTE, 1'b1, addr + lane);
                loadRam(memStagePkg::SIZE_BYTE, 1'b0, addr + lane);
                loadRam(memStagePkg::SIZE_WORD, 1'b0, addr);
            end
            for (int half = 0; half < 4; half += 2) begin
                storeRam(memStagePkg::SIZE_HALF, addr + half, nextRandom(32));
                loadRam(memStagePkg::SIZE_HALF, 1'b1, addr + half);
                loadRam(memStagePkg::SIZE_HALF, 1'b0, addr + half);
                loadRam(memStagePkg::SIZE_WORD, 1'b0, addr);
            end
        end

        // Exceptions must leave memory untouched
        addr = 32'h0000_0100;
        storeRam(memStagePkg::SIZE_WORD, addr, nextRandom(32));
        faultAccess(1'b1, memStagePkg::SIZE_WORD, addr + 2, 1'b0);
        faultAccess(1'b1, memStagePkg::SIZE_HALF, addr + 1, 1'b0);
        faultAccess(1'b0, memStagePkg::SIZE_WORD, addr + 3, 1'b0);
        faultAccess(1'b0, memStagePkg::SIZE_HALF, addr + 3, 1'b0);
        faultAccess(1'b1, memStagePkg::SIZE_WORD, 32'h0000_3000, 1'b0);
        faultAccess(1'b0, memStagePkg::SIZE_WORD, 32'h0000_7f30, 1'b0);
        faultAccess(1'b1, memStagePkg::SIZE_HALF, PRESET0, 1'b0);
        faultAccess(1'b0, memStagePkg::SIZE_BYTE, memStagePkg::TIMER1_BASE, 1'b0);
        faultAccess(1'b1, memStagePkg::SIZE_WORD, COUNT0, 1'b0);
        faultAccess(1'b1, memStagePkg::SIZE_WORD, addr, 1'b1);
        faultAccess(1'b0, memStagePkg::SIZE_WORD, addr, 1'b1);
        loadRam(memStagePkg::SIZE_WORD, 1'b0, addr);
        loadPeriph(PRESET0, 32'h0);
        loadPeriph(COUNT0, 32'h0);

        // Timer 0 countdown from 5
        storePeriph(PRESET0, 32'd5);
        storePeriph(CTRL0, 32'd1);
        // CTRL lands in stage 2, so read d behind it sees 6 - d
        for (int d = 1; d <= 7; d++) begin
            loadPeriph(COUNT0, (d < 6) ? 32'(6 - d) : 32'd0);
            if (d == 3) begin
                checkValue("timerIrq", 32'(timerIrq), 32'h0);
            end
        end
        idle(8);
        checkValue("timerIrq", 32'(timerIrq), 32'h1);
        value = nextRandom(32);
        storePeriph(memStagePkg::SCRATCH_BASE, value);
        loadPeriph(memStagePkg::SCRATCH_BASE, value);
        idle(int'(memStagePkg::PIPE_DEPTH) + 4);

        if ((pending.size() == 0) && (memSubsystem_i.memSubsystemProps_i.failCount == 0)) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Run ended with %0d results never seen and %0d property failures",
                     pending.size(), memSubsystem_i.memSubsystemProps_i.failCount);
            $display("TESTBENCH FAILED");
            $fatal(1, "Run ended with errors");
        end
    end

    // Watchdog
    initial begin
        repeat (REQUEST_COUNT * 4 + 500) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog timeout");
    end

endmodule

`default_nettype wire

//--- verification/memSubsystem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem_properties (
    input wire logic       clk,
    input wire logic       rstN,
    input wire logic       reqValid,
    input wire logic       reqWrite,
    input wire logic       respValid,
    input wire logic       excValid,
    input wire logic [1:0] timerIrq
);

    // Count of failed assertions
    int failCount = 0;

    ////////////////////
    // Reset state
    ////////////////////
    idleAfterReset: assert property (@(posedge clk)
        $rose(rstN) |-> (!respValid && !excValid && (timerIrq == 2'b00)))
        else begin
            failCount++;
            $error("Outputs are not idle on the first cycle after reset");
        end

    // A load result and an exception never share a cycle
    oneResultKind: assert property (@(posedge clk) disable iff (!rstN)
        !(respValid && excValid))
        else begin
            failCount++;
            $error("respValid and excValid are high in the same cycle");
        end

    ////////////////////
    // Latency
    ////////////////////
    loadLatency: assert property (@(posedge clk) disable iff (!rstN)
        (reqValid && !reqWrite) |-> ##(memStagePkg::PIPE_DEPTH) (respValid || excValid))
        else begin
            failCount++;
            $error("Load gave neither data nor exception after the pipeline depth");
        end

    storeLatency: assert property (@(posedge clk) disable iff (!rstN)
        (reqValid && reqWrite) |-> ##(memStagePkg::PIPE_DEPTH) !respValid)
        else begin
            failCount++;
            $error("Store produced load data");
        end

    idleLatency: assert property (@(posedge clk) disable iff (!rstN)
        !reqValid |-> ##(memStagePkg::PIPE_DEPTH) (!respValid && !excValid))
        else begin
            failCount++;
            $error("Result appeared without a request");
        end

endmodule

bind memSubsystem memSubsystem_properties memSubsystemProps_i (
    .clk       (clk),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .reqWrite  (reqWrite),
    .respValid (respValid),
    .excValid  (excValid),
    .timerIrq  (timerIrq)
);

`default_nettype wire
